// ==== Bender.yml ====
package:
  name: ts_dram

sources:
  - files:
      - rtl/ts_pkg.sv
      - rtl/dram_if.sv
      - rtl/dram_arbiter.sv
      - rtl/dram_array.sv
      - rtl/cpu_mem_port.sv
      - rtl/dma_copy.sv
      - rtl/ts_top.sv
  - target: test
    files:
      - dv/tb_clkgen.sv
      - dv/arbiter_chk.sv
      - dv/tb_top.sv

// ==== dv/arbiter_chk.sv ====
`timescale 1ns/1ps

module arbiter_chk (
	input logic fclk,
	input logic rst_n,
	input ts_pkg::phase_t phase,
	input logic mem_req,
	input logic cpu_req,
	input logic cpu_next,
	input logic dma_req,
	input logic dma_next
);
	import ts_pkg::*;

	// number of failed assertions
	int err_count = 0;

	// memory strobe is a single C0 pulse
	mem_strobe_single: assert property (@(posedge fclk) disable iff (!rst_n)
		mem_req |=> !mem_req)
		else begin
			err_count++;
			$error("mem strobe high for two cycles in a row");
		end

	// one owner per cycle
	next_exclusive: assert property (@(posedge fclk) disable iff (!rst_n)
		!(cpu_next && dma_next))
		else begin
			err_count++;
			$error("cpu and dma next strobes high together");
		end

	// next only toward a waiting requester
	next_needs_req: assert property (@(posedge fclk) disable iff (!rst_n)
		(cpu_next |-> cpu_req) and (dma_next |-> dma_req))
		else begin
			err_count++;
			$error("next strobe on a channel without req");
		end

	phase_steps: assert property (@(posedge fclk) disable iff (!rst_n)
		$past(rst_n) |-> phase == phase_t'($past(phase) + 2'd1))
		else begin
			err_count++;
			$error("dram phase did not advance by one");
		end

endmodule

bind dram_arbiter arbiter_chk chk (
	.fclk(fclk),
	.rst_n(rst_n),
	.phase(phase),
	.mem_req(mem.req),
	.cpu_req(cpu.req),
	.cpu_next(cpu.next),
	.dma_req(dma.req),
	.dma_next(dma.next)
);

// ==== dv/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen (
	output logic fclk,
	output logic rst_n
);

	// 8 ns period
	initial begin
		fclk = 1'b0;
		forever #4 fclk = ~fclk;
	end

	// reset held over the first 10 rising edges
	initial begin
		rst_n = 1'b0;
		repeat (10) @(posedge fclk);
		#1;
		rst_n = 1'b1;
	end

endmodule

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;
	import ts_pkg::*;

	logic fclk;
	logic rst_n;
	logic cpu_req;
	logic cpu_rnw;
	logic [ADDR_W-1:0] cpu_addr;
	logic [DATA_W-1:0] cpu_wrdata;
	logic cpu_ack;
	logic [DATA_W-1:0] cpu_rddata;
	logic dma_req;
	logic [ADDR_W-1:0] dma_src;
	logic [ADDR_W-1:0] dma_dst;
	logic [LEN_W-1:0] dma_len;
	logic dma_ack;

	// expected memory contents
	logic [DATA_W-1:0] ref_mem [MEM_WORDS];
	logic [15:0] lfsr;

	tb_clkgen clkgen (.fclk(fclk), .rst_n(rst_n));

	ts_top UUT (.*);

	// right-shifting form of x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] next_lfsr(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	task automatic random_bits(input int n, output logic [31:0] value);
		int i;
		value = '0;
		for (i = 0; i < n; i++) begin
			lfsr = next_lfsr(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			stop_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	// inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge fclk);
		#1;
	endtask

	task automatic wait_ack(input bit on_dma, input logic level, input int limit);
		int cycles;
		cycles = 0;
		while ((on_dma ? dma_ack : cpu_ack) !== level) begin
			if (cycles >= limit) begin
				stop_run($sformatf("timeout: %s never went to %0d",
					on_dma ? "dma_ack" : "cpu_ack", level));
			end
			next_cycle();
			cycles++;
		end
	endtask

	task automatic cpu_access(input logic rnw, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wrdata, input int hold,
			output logic [DATA_W-1:0] rddata);
		cpu_rnw = rnw;
		cpu_addr = addr;
		cpu_wrdata = wrdata;
		cpu_req = 1'b1;
		wait_ack(1'b0, 1'b1, 40);
		rddata = cpu_rddata;
		// ack must stay up while req is held
		repeat (hold) begin
			next_cycle();
			check_value("cpu_ack", cpu_ack, 1);
		end
		cpu_req = 1'b0;
		wait_ack(1'b0, 1'b0, 40);
	endtask

	task automatic cpu_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		logic [DATA_W-1:0] ignored;
		cpu_access(1'b0, addr, data, 0, ignored);
		ref_mem[addr] = data;
	endtask

	task automatic cpu_read_check(input logic [ADDR_W-1:0] addr);
		logic [DATA_W-1:0] got;
		cpu_access(1'b1, addr, '0, 0, got);
		check_value("cpu_rddata", got, ref_mem[addr]);
	endtask

	task automatic dma_run(input logic [ADDR_W-1:0] src, input logic [ADDR_W-1:0] dst,
			input logic [LEN_W-1:0] len, input int hold);
		int i;
		dma_src = src;
		dma_dst = dst;
		dma_len = len;
		dma_req = 1'b1;
		wait_ack(1'b1, 1'b1, 4000);
		repeat (hold) begin
			next_cycle();
			check_value("dma_ack", dma_ack, 1);
		end
		dma_req = 1'b0;
		wait_ack(1'b1, 1'b0, 40);
		// word i moves from src+i to dst+i in order and wraps at the top
		for (i = 0; i < len; i++) begin
			ref_mem[ADDR_W'(dst + i)] = ref_mem[ADDR_W'(src + i)];
		end
	endtask

	task automatic fill_block(input logic [ADDR_W-1:0] base, input int n);
		int i;
		logic [31:0] r;
		for (i = 0; i < n; i++) begin
			random_bits(DATA_W, r);
			cpu_write(ADDR_W'(base + i), r[DATA_W-1:0]);
		end
	endtask

	task automatic check_block(input logic [ADDR_W-1:0] base, input int n);
		int i;
		for (i = 0; i < n; i++) begin
			cpu_read_check(ADDR_W'(base + i));
		end
	endtask

	task automatic test_reset_state();
		logic [31:0] r;
		logic [DATA_W-1:0] got;
		check_value("cpu_ack", cpu_ack, 0);
		check_value("dma_ack", dma_ack, 0);
		random_bits(ADDR_W, r);
		cpu_access(1'b1, r[ADDR_W-1:0], '0, 0, got);
		check_value("cpu_rddata", got, 0);
	endtask

	task automatic test_write_read();
		int i;
		logic [31:0] a;
		logic [31:0] d;
		for (i = 0; i < 16; i++) begin
			random_bits(ADDR_W, a);
			random_bits(DATA_W, d);
			cpu_write(a[ADDR_W-1:0], d[DATA_W-1:0]);
			cpu_read_check(a[ADDR_W-1:0]);
		end
	endtask

	task automatic test_dma_copy();
		fill_block(10'h100, 8);
		dma_run(10'h100, 10'h200, 8, 0);
		check_block(10'h200, 8);
		// source wraps past the top of memory
		fill_block(10'h3fc, 8);
		dma_run(10'h3fc, 10'h040, 8, 0);
		check_block(10'h040, 8);
	endtask

	task automatic test_dma_empty();
		fill_block(10'h180, 1);
		dma_run(10'h100, 10'h180, 0, 0);
		check_block(10'h180, 1);
	endtask

	task automatic test_dma_with_cpu();
		int i;
		logic [31:0] a;
		logic [31:0] d;
		fill_block(10'h280, 64);
		fork
			dma_run(10'h280, 10'h300, 64, 0);
			// cpu traffic in 0x080..0x0bf stays clear of both ranges
			for (i = 0; i < 12; i++) begin
				random_bits(6, a);
				random_bits(DATA_W, d);
				cpu_write(ADDR_W'(10'h080 + a), d[DATA_W-1:0]);
				cpu_read_check(ADDR_W'(10'h080 + a));
			end
		join
		check_block(10'h300, 64);
	endtask

	task automatic test_handshake_hold();
		logic [DATA_W-1:0] got;
		fill_block(10'h0c0, 1);
		cpu_access(1'b1, 10'h0c0, '0, 6, got);
		check_value("cpu_rddata", got, ref_mem[10'h0c0]);
		dma_run(10'h100, 10'h1c0, 2, 6);
		check_block(10'h1c0, 2);
	endtask

	// a failed arbiter assertion ends the run
	always @(posedge fclk) begin
		if (UUT.dram_arbiter.chk.err_count != 0) begin
			stop_run("an assertion in the arbiter checker failed");
		end
	end

	initial begin
		int cycles;
		int i;
		cpu_req = 1'b0;
		cpu_rnw = 1'b1;
		cpu_addr = '0;
		cpu_wrdata = '0;
		dma_req = 1'b0;
		dma_src = '0;
		dma_dst = '0;
		dma_len = '0;
		lfsr = 16'd12977;
		for (i = 0; i < MEM_WORDS; i++) begin
			ref_mem[i] = '0;
		end
		cycles = 0;
		while (rst_n !== 1'b1) begin
			if (cycles >= 40) begin
				stop_run("timeout: reset was never released");
			end
			@(posedge fclk);
			cycles++;
		end
		next_cycle();
		test_reset_state();
		test_write_read();
		test_dma_copy();
		test_dma_empty();
		test_dma_with_cpu();
		test_handshake_hold();
		next_cycle();
		if (UUT.dram_arbiter.chk.err_count != 0) begin
			stop_run("an assertion in the arbiter checker failed");
		end else begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

// ==== filelist.f ====
rtl/ts_pkg.sv
rtl/dram_if.sv
rtl/dram_arbiter.sv
rtl/dram_array.sv
rtl/cpu_mem_port.sv
rtl/dma_copy.sv
rtl/ts_top.sv
dv/tb_clkgen.sv
dv/arbiter_chk.sv
dv/tb_top.sv

// ==== rtl/cpu_mem_port.sv ====
`timescale 1ns/1ps

module cpu_mem_port (
	input logic fclk,
	input logic rst_n,
	input logic cpu_req,
	input logic cpu_rnw,
	input logic [ts_pkg::ADDR_W-1:0] cpu_addr,
	input logic [ts_pkg::DATA_W-1:0] cpu_wrdata,
	output logic cpu_ack,
	output logic [ts_pkg::DATA_W-1:0] cpu_rddata,
	dram_if.requester bus
);
	import ts_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT,
		ST_ACK
	} state_t;

	state_t state;

	always_ff @(posedge fclk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			bus.req <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: if (cpu_req) begin
					bus.req <= 1'b1;
					state <= ST_WAIT;
				end
				// one dram cycle per cpu request
				ST_WAIT: if (bus.next) begin
					bus.req <= 1'b0;
					state <= ST_ACK;
				end
				// hold ack until the cpu lets go
				ST_ACK: if (!cpu_req) begin
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// request payload taken once at the start
	always_ff @(posedge fclk) begin
		if (state == ST_IDLE && cpu_req) begin
			bus.rnw <= cpu_rnw;
			bus.addr <= cpu_addr;
			bus.wrdata <= cpu_wrdata;
		end
		if (state == ST_WAIT && bus.next && bus.rnw) begin
			cpu_rddata <= bus.rddata;
		end
	end

	assign cpu_ack = (state == ST_ACK);

endmodule

// ==== rtl/dma_copy.sv ====
`timescale 1ns/1ps

module dma_copy (
	input logic fclk,
	input logic rst_n,
	input logic dma_req,
	input logic [ts_pkg::ADDR_W-1:0] dma_src,
	input logic [ts_pkg::ADDR_W-1:0] dma_dst,
	input logic [ts_pkg::LEN_W-1:0] dma_len,
	output logic dma_ack,
	dram_if.requester bus
);
	import ts_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_WRITE,
		ST_DONE
	} state_t;

	state_t state;
	logic [ADDR_W-1:0] src;
	logic [ADDR_W-1:0] dst;
	logic [LEN_W-1:0] remain;
	logic [DATA_W-1:0] word_buf;

	always_ff @(posedge fclk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				// an empty block is done at once
				ST_IDLE: if (dma_req) begin
					state <= (dma_len == '0) ? ST_DONE : ST_READ;
				end
				ST_READ: if (bus.next) begin
					state <= ST_WRITE;
				end
				ST_WRITE: if (bus.next) begin
					state <= (remain == LEN_W'(1)) ? ST_DONE : ST_READ;
				end
				ST_DONE: if (!dma_req) begin
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// counters and the one-word buffer
	always_ff @(posedge fclk) begin
		if (state == ST_IDLE && dma_req) begin
			src <= dma_src;
			dst <= dma_dst;
			remain <= dma_len;
		end
		if (state == ST_READ && bus.next) begin
			word_buf <= bus.rddata;
		end
		// both addresses wrap with the address width
		if (state == ST_WRITE && bus.next) begin
			src <= src + 1'b1;
			dst <= dst + 1'b1;
			remain <= remain - 1'b1;
		end
	end

	// req stays up between the read and write of a word
	assign bus.req = (state == ST_READ) || (state == ST_WRITE);
	assign bus.rnw = (state == ST_READ);
	assign bus.addr = (state == ST_READ) ? src : dst;
	assign bus.wrdata = word_buf;

	assign dma_ack = (state == ST_DONE);

endmodule

// ==== rtl/dram_arbiter.sv ====
`timescale 1ns/1ps

module dram_arbiter (
	input logic fclk,
	input logic rst_n,
	dram_if.arb cpu,
	dram_if.arb dma,
	dram_if.requester mem
);
	import ts_pkg::*;

	phase_t phase;
	owner_t owner;
	owner_t choice;

	// cpu always wins over dma
	always_comb begin
		if (cpu.req) begin
			choice = OWN_CPU;
		end else if (dma.req) begin
			choice = OWN_DMA;
		end else begin
			choice = OWN_NONE;
		end
	end

	// phase counter, owner and strobes
	always_ff @(posedge fclk) begin
		if (!rst_n) begin
			phase <= PH_C0;
			owner <= OWN_NONE;
			mem.req <= 1'b0;
			cpu.next <= 1'b0;
			dma.next <= 1'b0;
		end else begin
			phase <= phase_t'(phase + 2'd1);

			// decision for the cycle starting at C0
			if (phase == PH_C3) begin
				owner <= choice;
			end

			// memory strobe lives in C0 only
			mem.req <= (phase == PH_C3) && (choice != OWN_NONE);

			// next lives in C2, after the array has answered in C1
			cpu.next <= (phase == PH_C1) && (owner == OWN_CPU);
			dma.next <= (phase == PH_C1) && (owner == OWN_DMA);
		end
	end

	// request of the granted owner, frozen for the whole cycle
	always_ff @(posedge fclk) begin
		if (phase == PH_C3) begin
			if (choice == OWN_DMA) begin
				mem.rnw <= dma.rnw;
				mem.addr <= dma.addr;
				mem.wrdata <= dma.wrdata;
			end else begin
				mem.rnw <= cpu.rnw;
				mem.addr <= cpu.addr;
				mem.wrdata <= cpu.wrdata;
			end
		end
	end

	// read word goes back only to whoever owns the cycle
	assign cpu.rddata = (owner == OWN_CPU) ? mem.rddata : '0;
	assign dma.rddata = (owner == OWN_DMA) ? mem.rddata : '0;

endmodule

// ==== rtl/dram_array.sv ====
`timescale 1ns/1ps

module dram_array (
	input logic fclk,
	dram_if.mem mem
);
	import ts_pkg::*;

	logic [DATA_W-1:0] words [MEM_WORDS];

	// start from an all-zero memory
	initial begin
		for (int i = 0; i < MEM_WORDS; i++) begin
			words[i] = '0;
		end
	end

	// write port
	always @(posedge fclk) begin
		if (mem.req && !mem.rnw) begin
			words[mem.addr] <= mem.wrdata;
		end
	end

	// registered read, valid one cycle after the strobe
	// and held until the next read
	always_ff @(posedge fclk) begin
		if (mem.req && mem.rnw) begin
			mem.rddata <= words[mem.addr];
		end
	end

endmodule

// ==== rtl/dram_if.sv ====
`timescale 1ns/1ps

interface dram_if;
	import ts_pkg::*;

	// level request, held until next
	logic req;
	logic rnw;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wrdata;

	// answer side
	logic [DATA_W-1:0] rddata;
	logic next;

	modport requester (
		output req,
		output rnw,
		output addr,
		output wrdata,
		input rddata,
		input next
	);

	modport arb (
		input req,
		input rnw,
		input addr,
		input wrdata,
		output rddata,
		output next
	);

	// req is a single-cycle strobe here
	modport mem (
		input req,
		input rnw,
		input addr,
		input wrdata,
		output rddata
	);

endinterface

// ==== rtl/ts_pkg.sv ====
package ts_pkg;

	// shared dram geometry
	// one word per address
	localparam int ADDR_W = 10;
	localparam int DATA_W = 16;

	// the array covers the whole address space
	localparam int MEM_WORDS = 1 << ADDR_W;

	// dma block length in words, 0 to 1023
	localparam int LEN_W = 10;

	// four fclk phases of one dram bus cycle
	// C3 decides, C0 strobes, C1 reads, C2 answers
	typedef enum logic [1:0] {
		PH_C0,
		PH_C1,
		PH_C2,
		PH_C3
	} phase_t;

	// owner of the current dram cycle
	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_CPU,
		OWN_DMA
	} owner_t;

endpackage

// ==== rtl/ts_top.sv ====
`timescale 1ns/1ps

module ts_top (
	input logic fclk,
	input logic rst_n,

	// cpu memory access
	input logic cpu_req,
	input logic cpu_rnw,
	input logic [ts_pkg::ADDR_W-1:0] cpu_addr,
	input logic [ts_pkg::DATA_W-1:0] cpu_wrdata,
	output logic cpu_ack,
	output logic [ts_pkg::DATA_W-1:0] cpu_rddata,

	// dma block copy
	input logic dma_req,
	input logic [ts_pkg::ADDR_W-1:0] dma_src,
	input logic [ts_pkg::ADDR_W-1:0] dma_dst,
	input logic [ts_pkg::LEN_W-1:0] dma_len,
	output logic dma_ack
);

	dram_if cpu_bus ();
	dram_if dma_bus ();
	dram_if mem_bus ();

	cpu_mem_port cpu_mem_port
	(
		.fclk(fclk),
		.rst_n(rst_n),
		.cpu_req(cpu_req),
		.cpu_rnw(cpu_rnw),
		.cpu_addr(cpu_addr),
		.cpu_wrdata(cpu_wrdata),
		.cpu_ack(cpu_ack),
		.cpu_rddata(cpu_rddata),
		.bus(cpu_bus.requester)
	);

	dma_copy dma_copy
	(
		.fclk(fclk),
		.rst_n(rst_n),
		.dma_req(dma_req),
		.dma_src(dma_src),
		.dma_dst(dma_dst),
		.dma_len(dma_len),
		.dma_ack(dma_ack),
		.bus(dma_bus.requester)
	);

	dram_arbiter dram_arbiter
	(
		.fclk(fclk),
		.rst_n(rst_n),
		.cpu(cpu_bus.arb),
		.dma(dma_bus.arb),
		.mem(mem_bus.requester)
	);

	dram_array dram_array
	(
		.fclk(fclk),
		.mem(mem_bus.mem)
	);

endmodule
